// File: hw/pcs_rx_decoder_top.sv
// 10GBASE-R receive decoder top: block classifier feeding the sequence check FSM
`timescale 1ns/1ps

module pcs_rx_decoder_top
	import pcs_rx_pkg::*;
(
	input  logic         i_clock,
	input  logic         i_reset,
	input  logic         i_enable,
	input  block_t       i_block,
	input  logic         i_block_valid,
	output data_t        o_rx_data,
	output ctrl_t        o_rx_ctrl,
	output logic         o_rx_valid,
	output logic         o_frame_gap,
	output error_count_t o_error_count
);

	data_t   cls_data;
	ctrl_t   cls_ctrl;
	r_type_e cls_r_type;
	r_type_e cls_r_type_next;  // type of the block behind
	logic    cls_valid;

	rx_block_classifier u_classifier
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_enable      (i_enable),
		.i_block       (i_block),
		.i_block_valid (i_block_valid),
		.o_data        (cls_data),
		.o_ctrl        (cls_ctrl),
		.o_r_type      (cls_r_type),
		.o_r_type_next (cls_r_type_next),
		.o_valid       (cls_valid)
	);

	rx_decoder_fsm u_decoder_fsm
	(
		.i_clock          (i_clock),
		.i_reset          (i_reset),
		.i_enable         (i_enable),
		.i_valid          (cls_valid),
		.i_r_type         (cls_r_type),
		.i_r_type_next    (cls_r_type_next),
		.i_rx_data        (cls_data),
		.i_rx_control     (cls_ctrl),
		.o_rx_raw_data    (o_rx_data),
		.o_rx_raw_control (o_rx_ctrl),
		.o_rx_valid       (o_rx_valid),
		.o_frame_gap      (o_frame_gap),
		.o_error_count    (o_error_count)
	);

endmodule

// File: hw/pcs_rx_pkg.sv
// 10GBASE-R receive PCS shared widths, block codes, XGMII characters and enums
package pcs_rx_pkg;

	// widths
	localparam int LANES             = 8;
	localparam int LANE_WIDTH        = 8;
	localparam int DATA_WIDTH        = LANES * LANE_WIDTH;
	localparam int CTRL_WIDTH        = LANES;
	localparam int SYNC_WIDTH        = 2;
	localparam int BLOCK_WIDTH       = SYNC_WIDTH + DATA_WIDTH;
	localparam int ERROR_COUNT_WIDTH = 32;

	typedef logic [BLOCK_WIDTH-1:0]       block_t;       // sync header on top
	typedef logic [DATA_WIDTH-1:0]        data_t;        // lane 0 in low byte
	typedef logic [CTRL_WIDTH-1:0]        ctrl_t;        // one flag per lane
	typedef logic [ERROR_COUNT_WIDTH-1:0] error_count_t;

	// sync headers, bits 65..64 of the block
	localparam logic [SYNC_WIDTH-1:0] SYNC_DATA = 2'b01;
	localparam logic [SYNC_WIDTH-1:0] SYNC_CTRL = 2'b10;

	// block type field of a control block, payload bits 7..0
	localparam logic [LANE_WIDTH-1:0] BT_IDLE  = 8'h1E;
	localparam logic [LANE_WIDTH-1:0] BT_START = 8'h78;
	localparam logic [LANE_WIDTH-1:0] BT_TERM0 = 8'h87;
	localparam logic [LANE_WIDTH-1:0] BT_TERM1 = 8'h99;
	localparam logic [LANE_WIDTH-1:0] BT_TERM2 = 8'hAA;
	localparam logic [LANE_WIDTH-1:0] BT_TERM3 = 8'hB4;
	localparam logic [LANE_WIDTH-1:0] BT_TERM4 = 8'hCC;
	localparam logic [LANE_WIDTH-1:0] BT_TERM5 = 8'hD2;
	localparam logic [LANE_WIDTH-1:0] BT_TERM6 = 8'hE1;
	localparam logic [LANE_WIDTH-1:0] BT_TERM7 = 8'hFF;

	// XGMII control characters
	localparam logic [LANE_WIDTH-1:0] XG_IDLE  = 8'h07;
	localparam logic [LANE_WIDTH-1:0] XG_START = 8'hFB;
	localparam logic [LANE_WIDTH-1:0] XG_TERM  = 8'hFD;
	localparam logic [LANE_WIDTH-1:0] XG_ERROR = 8'hFE;

	// error block sent in place of a bad block
	localparam data_t ERROR_DATA = {LANES{XG_ERROR}};
	localparam ctrl_t ERROR_CTRL = {CTRL_WIDTH{1'b1}};

	// block classes as seen by the decoder
	typedef enum logic [2:0]
	{
		TYPE_C,  // all idle
		TYPE_S,  // start in lane 0
		TYPE_D,  // all data
		TYPE_T,  // one of the eight terminates
		TYPE_E   // anything else
	} r_type_e;

	// receive decoder states
	typedef enum logic [2:0]
	{
		RX_INIT,
		RX_C,
		RX_D,
		RX_T,
		RX_E
	} rx_state_e;

endpackage

// File: hw/rx_block_classifier.sv
// 64b/66b block classifier: decodes blocks to XGMII lanes with one-block type lookahead
`timescale 1ns/1ps

module rx_block_classifier
	import pcs_rx_pkg::*;
(
	input  logic    i_clock,
	input  logic    i_reset,
	input  logic    i_enable,
	input  block_t  i_block,
	input  logic    i_block_valid,
	output data_t   o_data,
	output ctrl_t   o_ctrl,
	output r_type_e o_r_type,
	output r_type_e o_r_type_next,
	output logic    o_valid
);

	// terminate codes, code k sits at byte k
	localparam logic [DATA_WIDTH-1:0] TERM_CODES =
	{
		BT_TERM7, BT_TERM6, BT_TERM5, BT_TERM4,
		BT_TERM3, BT_TERM2, BT_TERM1, BT_TERM0
	};

	logic [SYNC_WIDTH-1:0] sync;
	data_t                 payload;
	data_t                 payload_shifted;  // payload byte i+1 in lane i
	logic [LANE_WIDTH-1:0] block_type;
	logic                  idle_clean;

	logic                  term_hit;
	int                    term_lane;

	data_t                 dec_data;
	ctrl_t                 dec_ctrl;
	r_type_e               dec_type;

	logic                  accept;

	// lookahead stage
	data_t                 look_data;
	ctrl_t                 look_ctrl;
	r_type_e               look_type;
	logic                  look_full;

	assign sync            = i_block[BLOCK_WIDTH-1 -: SYNC_WIDTH];
	assign payload         = i_block[DATA_WIDTH-1:0];
	assign payload_shifted = payload >> LANE_WIDTH;
	assign block_type      = payload[LANE_WIDTH-1:0];
	assign idle_clean      = (payload[DATA_WIDTH-1:LANE_WIDTH] == '0);
	assign accept          = i_enable && i_block_valid;

	// which terminate, if any
	always_comb
	begin
		term_hit  = 1'b0;
		term_lane = 0;
		for (int k = 0; k < LANES; k++)
		begin
			if (block_type == TERM_CODES[k*LANE_WIDTH +: LANE_WIDTH])
			begin
				term_hit  = 1'b1;
				term_lane = k;
			end
		end
	end

	always_comb
	begin
		dec_data = ERROR_DATA;  // default for anything unknown
		dec_ctrl = ERROR_CTRL;
		dec_type = TYPE_E;

		if (sync == SYNC_DATA)
		begin
			dec_data = payload;
			dec_ctrl = '0;
			dec_type = TYPE_D;
		end
		else if (sync == SYNC_CTRL)
		begin
			if (block_type == BT_IDLE && idle_clean)
			begin
				dec_data = {LANES{XG_IDLE}};
				dec_ctrl = '1;
				dec_type = TYPE_C;
			end
			else if (block_type == BT_START)
			begin
				dec_data = {payload[DATA_WIDTH-1:LANE_WIDTH], XG_START};
				dec_ctrl = ctrl_t'(1);  // only lane 0 is control
				dec_type = TYPE_S;
			end
			else if (term_hit)
			begin
				for (int i = 0; i < LANES; i++)
				begin
					if (i < term_lane)
						dec_data[i*LANE_WIDTH +: LANE_WIDTH] =
							payload_shifted[i*LANE_WIDTH +: LANE_WIDTH];
					else if (i == term_lane)
						dec_data[i*LANE_WIDTH +: LANE_WIDTH] = XG_TERM;
					else
						dec_data[i*LANE_WIDTH +: LANE_WIDTH] = XG_IDLE;
					dec_ctrl[i] = (i >= term_lane);  // control from the T lane up
				end
				dec_type = TYPE_T;
			end
		end
	end

	// new block into lookahead, previous one out with its successor's type
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			look_full     <= 1'b0;
			look_type     <= TYPE_E;
			o_r_type      <= TYPE_E;
			o_r_type_next <= TYPE_E;
			o_valid       <= 1'b0;
		end
		else if (i_enable)
		begin
			o_valid <= accept && look_full;
			if (accept)
			begin
				look_full     <= 1'b1;
				look_type     <= dec_type;
				o_r_type      <= look_type;
				o_r_type_next <= dec_type;
			end
		end
	end

	// lane payload, no reset
	always_ff @(posedge i_clock)
	begin
		if (accept)
		begin
			look_data <= dec_data;
			look_ctrl <= dec_ctrl;
			o_data    <= look_data;
			o_ctrl    <= look_ctrl;
		end
	end

endmodule

// File: hw/rx_decoder_fsm.sv
// receive decoder FSM: checks block order, substitutes error blocks and counts them
`timescale 1ns/1ps

module rx_decoder_fsm
	import pcs_rx_pkg::*;
(
	input  logic         i_clock,
	input  logic         i_reset,
	input  logic         i_enable,
	input  logic         i_valid,
	input  r_type_e      i_r_type,
	input  r_type_e      i_r_type_next,
	input  data_t        i_rx_data,
	input  ctrl_t        i_rx_control,
	output data_t        o_rx_raw_data,
	output ctrl_t        o_rx_raw_control,
	output logic         o_rx_valid,
	output logic         o_frame_gap,
	output error_count_t o_error_count
);

	rx_state_e state;
	rx_state_e state_next;

	logic      step;          // one block to process this cycle
	logic      term_ok;       // terminate followed by idle or start
	logic      to_error;
	logic      gap;

	assign step     = i_enable && i_valid;
	assign term_ok  = (i_r_type_next == TYPE_C) || (i_r_type_next == TYPE_S);
	assign to_error = (state_next == RX_E);
	assign gap      = (state == RX_T) && (state_next == RX_C);

	always_comb
	begin
		state_next = RX_E;

		case (state)
			RX_INIT, RX_C, RX_T:
			begin
				if (i_r_type == TYPE_C)
					state_next = RX_C;
				else if (i_r_type == TYPE_S)
					state_next = RX_D;
			end

			RX_D:
			begin
				if (i_r_type == TYPE_D)
					state_next = RX_D;
				else if (i_r_type == TYPE_T && term_ok)
					state_next = RX_T;
			end

			RX_E:
			begin
				// recovery also allowed straight into a frame
				if (i_r_type == TYPE_C)
					state_next = RX_C;
				else if (i_r_type == TYPE_S || i_r_type == TYPE_D)
					state_next = RX_D;
				else if (i_r_type == TYPE_T && term_ok)
					state_next = RX_T;
			end

			default:
			begin
				state_next = RX_E;
			end
		endcase
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state            <= RX_INIT;
			o_rx_raw_data    <= '0;
			o_rx_raw_control <= '0;
			o_rx_valid       <= 1'b0;
			o_frame_gap      <= 1'b0;
			o_error_count    <= '0;
		end
		else
		begin
			o_rx_valid  <= step;
			o_frame_gap <= step && gap;  // idle right after an accepted terminate

			if (step)
			begin
				state <= state_next;
				if (to_error)
				begin
					o_rx_raw_data    <= ERROR_DATA;
					o_rx_raw_control <= ERROR_CTRL;
					o_error_count    <= o_error_count + error_count_t'(1);
				end
				else
				begin
					o_rx_raw_data    <= i_rx_data;
					o_rx_raw_control <= i_rx_control;
				end
			end
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the receive decoder testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 -f sim.f --top-module tb_pcs_rx \
	-Mdir "$BUILD_DIR" -o tb_pcs_rx
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/tb_pcs_rx" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: sim.f
hw/pcs_rx_pkg.sv
hw/rx_block_classifier.sv
hw/rx_decoder_fsm.sv
hw/pcs_rx_decoder_top.sv
verification/tb_clock_gen.sv
verification/tb_pcs_rx.sv

// File: verification/tb_clock_gen.sv
// testbench clock and reset source for the receive decoder
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic o_clock,
	output logic o_reset
);

	localparam realtime HALF_PERIOD  = 4ns;  // 8 ns clock
	localparam int      RESET_CYCLES = 16;

	initial
	begin
		o_clock = 1'b0;
		forever
			#(HALF_PERIOD) o_clock = ~o_clock;
	end

	initial
	begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_reset <= 1'b0;  // released on a rising edge
	end

endmodule

// File: verification/tb_pcs_rx.sv
// receive decoder testbench: directed tests checked against a behavioral block model
`timescale 1ns/1ps

module tb_pcs_rx
	import pcs_rx_pkg::*;
();

	localparam int DRAIN_TIMEOUT = 200;
	localparam int RESET_TIMEOUT = 100;

	logic         clock;
	logic         reset;
	logic         enable;
	block_t       blk;
	logic         blk_valid;
	data_t        rx_data;
	ctrl_t        rx_ctrl;
	logic         rx_valid;
	logic         frame_gap;
	error_count_t error_count;

	// model of the DUT, one block held back
	rx_state_e    model_state;
	error_count_t model_count;
	logic         pend_full;
	r_type_e      pend_type;
	data_t        pend_data;
	ctrl_t        pend_ctrl;
	data_t        exp_data[$];
	ctrl_t        exp_ctrl[$];
	error_count_t exp_count[$];
	logic         exp_gap[$];

	string        test_name;
	int           gaps_seen;
	logic [31:0]  lfsr_state;

	tb_clock_gen clock_gen0 (.o_clock(clock), .o_reset(reset));

	pcs_rx_decoder_top dut0
	(
		.i_clock       (clock),
		.i_reset       (reset),
		.i_enable      (enable),
		.i_block       (blk),
		.i_block_valid (blk_valid),
		.o_rx_data     (rx_data),
		.o_rx_ctrl     (rx_ctrl),
		.o_rx_valid    (rx_valid),
		.o_frame_gap   (frame_gap),
		.o_error_count (error_count)
	);

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input string what, input data_t exp, input data_t act);
		if (exp !== act)
		begin
			$display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_ctrl(input string what, input ctrl_t exp, input ctrl_t act);
		if (exp !== act)
		begin
			$display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_count(input string what, input error_count_t exp,
		input error_count_t act);
		if (exp !== act)
		begin
			$display("Fail %s: %s expected %0d actual %0d", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("Fail %s: %s expected %b actual %b", test_name, what, exp, act);
			abort_run();
		end
	endtask

	// fibonacci LFSR, taps 32 22 2 1
	function automatic logic lfsr_step();
		logic fb;
		fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[62:0], lfsr_step()};
		return r;
	endfunction

	function automatic logic [7:0] term_code(input int k);
		case (k)
			0: return BT_TERM0;
			1: return BT_TERM1;
			2: return BT_TERM2;
			3: return BT_TERM3;
			4: return BT_TERM4;
			5: return BT_TERM5;
			6: return BT_TERM6;
			default: return BT_TERM7;
		endcase
	endfunction

	function automatic block_t ctrl_block(input logic [7:0] bt, input logic [55:0] rest);
		return {SYNC_CTRL, rest, bt};
	endfunction

	// expected lanes and type of one block
	function automatic r_type_e classify(input block_t b, output data_t d, output ctrl_t c);
		int k;
		d = ERROR_DATA;
		c = ERROR_CTRL;
		if (b[65:64] == SYNC_DATA)
		begin
			d = b[63:0];
			c = 8'h00;
			return TYPE_D;
		end
		if (b[65:64] != SYNC_CTRL)
			return TYPE_E;
		if (b[7:0] == BT_IDLE)
		begin
			if (b[63:8] != 56'h0)
				return TYPE_E;  // dirty idle
			d = {8{XG_IDLE}};
			c = 8'hFF;
			return TYPE_C;
		end
		if (b[7:0] == BT_START)
		begin
			d = {b[63:8], XG_START};
			c = 8'h01;
			return TYPE_S;
		end
		k = -1;
		for (int j = 0; j < 8; j++)
			if (b[7:0] == term_code(j))
				k = j;
		if (k < 0)
			return TYPE_E;
		for (int i = 0; i < 8; i++)
		begin
			if (i < k)
				d[i*8 +: 8] = b[(i+1)*8 +: 8];
			else
				d[i*8 +: 8] = (i == k) ? XG_TERM : XG_IDLE;
			c[i] = (i >= k);
		end
		return TYPE_T;
	endfunction

	// one decoder step of the model, queues the output it expects
	task automatic predict_block(input r_type_e t, input r_type_e tn, input data_t d,
		input ctrl_t c);
		rx_state_e nxt;
		logic      next_ok;
		data_t     out_data;
		ctrl_t     out_ctrl;
		next_ok  = (tn == TYPE_C) || (tn == TYPE_S);
		nxt      = RX_E;
		out_data = d;
		out_ctrl = c;
		if (model_state == RX_D)
		begin
			if (t == TYPE_D)
				nxt = RX_D;
			else if (t == TYPE_T && next_ok)
				nxt = RX_T;
		end
		else if (t == TYPE_C)
			nxt = RX_C;
		else if (t == TYPE_S)
			nxt = RX_D;
		else if (model_state == RX_E && t == TYPE_D)
			nxt = RX_D;
		else if (model_state == RX_E && t == TYPE_T && next_ok)
			nxt = RX_T;
		if (nxt == RX_E)
		begin
			out_data    = ERROR_DATA;
			out_ctrl    = ERROR_CTRL;
			model_count = model_count + error_count_t'(1);
		end
		exp_data.push_back(out_data);
		exp_ctrl.push_back(out_ctrl);
		exp_count.push_back(model_count);
		exp_gap.push_back(model_state == RX_T && nxt == RX_C);
		model_state = nxt;
	endtask

	task automatic send_block(input block_t b);
		data_t   d;
		ctrl_t   c;
		r_type_e t;
		t = classify(b, d, c);
		if (pend_full)
			predict_block(pend_type, t, pend_data, pend_ctrl);
		pend_full = 1'b1;
		pend_type = t;
		pend_data = d;
		pend_ctrl = c;
		@(posedge clock);
		blk       <= b;
		blk_valid <= 1'b1;
		@(posedge clock);
		blk_valid <= 1'b0;
	endtask

	task automatic send_idle();
		send_block(ctrl_block(BT_IDLE, 56'h0));
	endtask

	task automatic wait_outputs();
		int cycles;
		cycles = 0;
		while (exp_data.size() != 0)
		begin
			@(negedge clock);
			cycles++;
			if (cycles > DRAIN_TIMEOUT)
			begin
				$display("%s: timed out waiting for o_rx_valid", test_name);
				abort_run();
			end
		end
	endtask

	task automatic check_output();
		if (exp_data.size() == 0)
		begin
			$display("%s: o_rx_valid pulsed with no block expected", test_name);
			abort_run();
		end
		check_data("o_rx_data", exp_data.pop_front(), rx_data);
		check_ctrl("o_rx_ctrl", exp_ctrl.pop_front(), rx_ctrl);
		check_count("o_error_count", exp_count.pop_front(), error_count);
		check_flag("o_frame_gap", exp_gap.pop_front(), frame_gap);
	endtask

	always @(negedge clock)
	begin
		if (!reset && rx_valid)
		begin
			gaps_seen += int'(frame_gap);
			check_output();
		end
		else if (!reset)
			check_flag("o_frame_gap without o_rx_valid", 1'b0, frame_gap);
	end

	task automatic test_reset();
		test_name = "reset";
		check_flag("o_rx_valid", 1'b0, rx_valid);
		check_data("o_rx_data", '0, rx_data);
		check_ctrl("o_rx_ctrl", '0, rx_ctrl);
		check_count("o_error_count", '0, error_count);
		send_idle();  // stays in the lookahead
		repeat (8) @(posedge clock);
	endtask

	task automatic test_clean_frame();
		int gaps_before;
		test_name   = "clean_frame";
		gaps_before = gaps_seen;
		send_idle();
		send_block(ctrl_block(BT_START, 56'hC0FFEE_12345678));
		send_block({SYNC_DATA, 64'h0011223344556677});
		send_block({SYNC_DATA, 64'h8899AABBCCDDEEFF});
		send_block(ctrl_block(BT_TERM3, 56'h00000000A1B2C3));
		send_idle();
		send_idle();
		wait_outputs();
		check_count("o_error_count", '0, error_count);
		check_count("frame gaps", error_count_t'(gaps_before + 1), error_count_t'(gaps_seen));
	endtask

	task automatic test_order_errors();
		error_count_t start;
		test_name = "order_errors";
		start     = model_count;
		send_block({SYNC_DATA, 64'h0102030405060708});  // data after idle
		send_idle();
		send_block(ctrl_block(BT_START, 56'h11111111111111));
		send_block({SYNC_DATA, 64'h2222222222222222});
		send_block(ctrl_block(BT_START, 56'h33333333333333));  // start inside a frame
		send_idle();
		send_block(ctrl_block(BT_START, 56'h44444444444444));
		send_block(ctrl_block(BT_TERM2, 56'h00000000005555));  // data follows
		send_block({SYNC_DATA, 64'h6666666666666666});
		send_block(ctrl_block(BT_TERM0, 56'h0));
		send_idle();
		wait_outputs();
		check_count("o_error_count", start + error_count_t'(3), error_count);
	endtask

	task automatic test_recovery();
		error_count_t start;
		test_name = "recovery";
		start     = model_count;
		send_block({SYNC_DATA, 64'hDEADBEEF00000001});  // error, into RX_E
		send_block({SYNC_DATA, 64'hDEADBEEF00000002});  // passed, into RX_D
		send_block({SYNC_DATA, 64'hDEADBEEF00000003});
		send_block(ctrl_block(BT_TERM7, 56'h77665544332211));
		send_idle();
		send_block({2'b00, 64'h1E});
		send_idle();
		send_block({2'b11, 64'h1E});
		send_idle();
		send_block(ctrl_block(BT_IDLE, 56'h00000000000100));
		send_idle();
		wait_outputs();
		check_count("o_error_count", start + error_count_t'(4), error_count);
	endtask

	task automatic test_random_frames();
		error_count_t start;
		logic [63:0]  r;
		int           k;
		test_name = "random_frames";
		start     = model_count;
		for (int f = 0; f < 24; f++)
		begin
			r = rand_bits(56);
			send_block(ctrl_block(BT_START, r[55:0]));
			r = rand_bits(2);
			for (int n = 0; n < int'(r[1:0]); n++)
				send_block({SYNC_DATA, rand_bits(64)});
			r = rand_bits(3);
			k = int'(r[2:0]);
			r = rand_bits(56);
			send_block(ctrl_block(term_code(k), r[55:0]));
			send_idle();
			r = rand_bits(2);
			if (r[0])
				send_idle();
			repeat (int'(r[1])) @(posedge clock);  // vary the input rate
		end
		send_idle();
		wait_outputs();
		check_count("o_error_count", start, error_count);
	endtask

	task automatic test_enable_low();
		error_count_t start;
		test_name = "enable_low";
		start     = model_count;
		repeat (4) @(posedge clock);
		enable <= 1'b0;
		for (int i = 0; i < 3; i++)
		begin
			@(posedge clock);
			blk       <= {SYNC_DATA, 64'hBAD0BAD0BAD0BAD0};
			blk_valid <= 1'b1;
			@(posedge clock);
			blk_valid <= 1'b0;
		end
		repeat (8) @(posedge clock);
		@(negedge clock);
		check_count("o_error_count", start, error_count);
		@(posedge clock);
		enable <= 1'b1;
		repeat (2) @(posedge clock);
		send_idle();
		send_block(ctrl_block(BT_START, 56'hAB_CDEF01_234567));
		send_block({SYNC_DATA, 64'h0F1E2D3C4B5A6978});
		send_block(ctrl_block(BT_TERM5, 56'h0000AABBCCDDEE));
		send_idle();
		send_idle();
		wait_outputs();
		check_count("o_error_count", start, error_count);
	endtask

	initial
	begin
		int cycles;
		enable      = 1'b1;
		blk         = '0;
		blk_valid   = 1'b0;
		model_state = RX_INIT;
		model_count = '0;
		pend_full   = 1'b0;
		pend_type   = TYPE_E;
		pend_data   = '0;
		pend_ctrl   = '0;
		test_name   = "startup";
		gaps_seen   = 0;
		lfsr_state  = 32'h6555d2de;
		cycles      = 0;
		do
		begin
			@(negedge clock);
			cycles++;
			if (cycles > RESET_TIMEOUT)
			begin
				$display("reset was never released");
				abort_run();
			end
		end
		while (reset);
		test_reset();
		test_clean_frame();
		test_order_errors();
		test_recovery();
		test_random_frames();
		test_enable_low();
		$display("TEST OK");
		$finish;
	end

endmodule
